/* rtl/dht_consts.svh */
//--------------------------------------------------
// DHT constants
// Code length count, symbol RAM size and the
// stream ids of the four Huffman tables
//--------------------------------------------------
`ifndef DHT_CONSTS_SVH
`define DHT_CONSTS_SVH

// Canonical codes are 1 to 16 bits long
`define DHT_MAX_CODE_LEN 16

// Symbol storage shared by all tables
`define DHT_SYM_RAM_DEPTH 1024
`define DHT_PTR_W 10

// Table id bytes as they appear in the DHT segment
`define DHT_ID_Y_DC 8'h00
`define DHT_ID_Y_AC 8'h10
`define DHT_ID_CX_DC 8'h01
`define DHT_ID_CX_AC 8'h11

`endif

/* rtl/dht_load_pkg.sv */
//--------------------------------------------------
// DHT load types
// Configuration stream bytes and loader state
//--------------------------------------------------
`default_nettype none

package dht_load_pkg;

    // One byte of the DHT segment
    typedef logic [7:0] cfg_byte_t;

    // Symbols at one code length
    typedef logic [7:0] sym_count_t;

    // Up to 16 x 255 symbols left in a table
    typedef logic [11:0] sym_total_t;

    typedef enum logic [1:0] {
        LOAD_TABLE_ID,
        LOAD_COUNTS,
        LOAD_SYMBOLS
    } load_state_t;

endpackage

`default_nettype wire

/* rtl/dht_code_pkg.sv */
//--------------------------------------------------
// DHT code types
// Canonical codes, lengths, RAM pointers and
// lookup results
//--------------------------------------------------
`default_nettype none

`include "dht_consts.svh"

package dht_code_pkg;

    typedef logic [`DHT_MAX_CODE_LEN-1:0] code_t;

    // Length index, 0 means a 1 bit code
    typedef logic [$clog2(`DHT_MAX_CODE_LEN)-1:0] code_len_t;
    typedef logic [4:0] lookup_width_t;

    typedef logic [`DHT_PTR_W-1:0] sym_ptr_t;

    // 0 Y DC, 1 Y AC, 2 Cx DC, 3 Cx AC
    typedef logic [1:0] table_sel_t;
    typedef logic [7:0] symbol_t;

endpackage

`default_nettype wire

/* rtl/dht_load_fsm.sv */
//--------------------------------------------------
// DHT loader
// Parses table id, count and symbol bytes and
// steers the code generator and table select
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module dht_load_fsm (
    input  wire                        clk_i,
    input  wire                        rst_i,
    input  wire                        cfg_valid_i,
    input  wire dht_load_pkg::cfg_byte_t cfg_data_i,
    input  wire                        cfg_last_i,
    input  wire                        cur_len_empty_i,
    output logic                       cfg_accept_o,
    output logic                       table_start_o,
    output logic                       count_wr_o,
    output dht_code_pkg::code_len_t    count_idx_o,
    output logic                       sym_step_o,
    output logic                       len_skip_o,
    output dht_code_pkg::table_sel_t   table_sel_o
);
    import dht_load_pkg::*;
    import dht_code_pkg::*;

    load_state_t state_q;
    code_len_t   count_idx_q;
    table_sel_t  table_sel_q;
    sym_total_t  remain_q;
    sym_total_t  remain_next;
    table_sel_t  id_sel;
    logic        cfg_fire;

    // Stall one cycle on each length without symbols
    assign cfg_accept_o = !((state_q == LOAD_SYMBOLS) && cur_len_empty_i);
    assign cfg_fire     = cfg_valid_i && cfg_accept_o;

    assign table_start_o = cfg_fire && (state_q == LOAD_TABLE_ID);
    assign count_wr_o    = cfg_fire && (state_q == LOAD_COUNTS);
    assign count_idx_o   = count_idx_q;
    assign sym_step_o    = cfg_fire && (state_q == LOAD_SYMBOLS);
    assign len_skip_o    = cfg_valid_i && !cfg_accept_o;
    assign table_sel_o   = table_sel_q;

    assign remain_next = remain_q + sym_total_t'(cfg_data_i);

    // Unknown ids fall through to chroma AC
    always_comb
    begin
        case (cfg_data_i)
            `DHT_ID_Y_DC:  id_sel = 2'd0;
            `DHT_ID_Y_AC:  id_sel = 2'd1;
            `DHT_ID_CX_DC: id_sel = 2'd2;
            default:       id_sel = 2'd3;
        endcase
    end

    //--------------------------------------------------
    // Load state machine
    //--------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
        begin
            state_q     <= LOAD_TABLE_ID;
            count_idx_q <= '0;
            table_sel_q <= '0;
            remain_q    <= '0;
        end
        else if (cfg_fire)
        begin
            case (state_q)
                LOAD_TABLE_ID:
                begin
                    table_sel_q <= id_sel;
                    count_idx_q <= '0;
                    remain_q    <= '0;
                    if (!cfg_last_i)
                        state_q <= LOAD_COUNTS;
                end
                LOAD_COUNTS:
                begin
                    count_idx_q <= count_idx_q + 1'b1;
                    remain_q    <= remain_next;
                    if (cfg_last_i)
                        state_q <= LOAD_TABLE_ID;
                    // A table with no symbols at all ends here
                    else if (count_idx_q == code_len_t'(`DHT_MAX_CODE_LEN - 1))
                        state_q <= (remain_next == '0) ? LOAD_TABLE_ID : LOAD_SYMBOLS;
                end
                default:
                begin
                    remain_q <= remain_q - 1'b1;
                    if (cfg_last_i || (remain_q == sym_total_t'(1)))
                        state_q <= LOAD_TABLE_ID;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/dht_code_gen.sv */
//--------------------------------------------------
// DHT code generator
// Walks code lengths, builds canonical code bounds
// and the symbol RAM write pointer
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module dht_code_gen (
    input  wire                          clk_i,
    input  wire                          rst_i,
    input  wire                          table_start_i,
    input  wire                          count_wr_i,
    input  wire dht_code_pkg::code_len_t count_idx_i,
    input  wire dht_load_pkg::sym_count_t count_i,
    input  wire                          sym_step_i,
    input  wire                          len_skip_i,
    output logic                         cur_len_empty_o,
    output logic                         bound_wr_o,
    output dht_code_pkg::code_len_t      bound_len_o,
    output dht_code_pkg::code_t          bound_min_o,
    output dht_code_pkg::code_t          bound_max_o,
    output dht_code_pkg::sym_ptr_t       next_ptr_o
);
    import dht_load_pkg::*;
    import dht_code_pkg::*;

    sym_count_t counts_q [`DHT_MAX_CODE_LEN];
    code_len_t  len_q;
    sym_count_t in_len_q;
    code_t      code_q;
    sym_ptr_t   ptr_q;
    sym_count_t cur_count;
    logic       len_done;

    assign cur_count       = counts_q[len_q];
    assign cur_len_empty_o = (cur_count == '0);
    assign len_done        = (sym_count_t'(in_len_q + 1'b1) == cur_count);

    // Skipped lengths get max equal to min, so stale bounds never match
    assign bound_wr_o  = (sym_step_i && (in_len_q == '0)) || len_skip_i;
    assign bound_len_o = len_q;
    assign bound_min_o = code_q;
    assign bound_max_o = code_q + code_t'(cur_count);
    assign next_ptr_o  = ptr_q;

    // Symbol counts per length
    always_ff @(posedge clk_i)
    begin
        if (rst_i || table_start_i)
        begin
            for (int i = 0; i < `DHT_MAX_CODE_LEN; i++)
                counts_q[i] <= '0;
        end
        else if (count_wr_i)
            counts_q[count_idx_i] <= count_i;
    end

    //--------------------------------------------------
    // Canonical code walk
    //--------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (rst_i || table_start_i)
        begin
            len_q    <= '0;
            in_len_q <= '0;
            code_q   <= '0;
        end
        else if (sym_step_i)
        begin
            if (len_done)
            begin
                len_q    <= len_q + 1'b1;
                in_len_q <= '0;
                code_q   <= (code_q + 1'b1) << 1;
            end
            else
            begin
                in_len_q <= in_len_q + 1'b1;
                code_q   <= code_q + 1'b1;
            end
        end
        else if (len_skip_i)
        begin
            len_q  <= len_q + 1'b1;
            code_q <= code_q << 1;
        end
    end

    // Shared by all tables, only cleared on reset
    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            ptr_q <= '0;
        else if (sym_step_i)
            ptr_q <= ptr_q + 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/dht_code_bounds.sv */
//--------------------------------------------------
// DHT code bounds and lookup pipeline
// Stores min, max and pointer per table and length,
// matches the code length and forms the RAM address
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module dht_code_bounds (
    input  wire                           clk_i,
    input  wire                           rst_i,
    input  wire                           bound_wr_i,
    input  wire dht_code_pkg::table_sel_t table_sel_i,
    input  wire dht_code_pkg::code_len_t  bound_len_i,
    input  wire dht_code_pkg::code_t      bound_min_i,
    input  wire dht_code_pkg::code_t      bound_max_i,
    input  wire dht_code_pkg::sym_ptr_t   bound_ptr_i,
    input  wire                           lookup_req_i,
    input  wire dht_code_pkg::table_sel_t lookup_table_i,
    input  wire dht_code_pkg::code_t      lookup_input_i,
    output dht_code_pkg::sym_ptr_t        rd_addr_o,
    output logic                          lookup_valid_o,
    output dht_code_pkg::lookup_width_t   lookup_width_o
);
    import dht_code_pkg::*;

    code_t    min_q [4][`DHT_MAX_CODE_LEN];
    code_t    max_q [4][`DHT_MAX_CODE_LEN];
    sym_ptr_t ptr_q [4][`DHT_MAX_CODE_LEN];

    code_len_t     match_len;
    logic          s1_valid_q;
    code_len_t     s1_len_q;
    table_sel_t    s1_table_q;
    code_t         s1_window_q;
    code_t         s2_prefix;
    code_t         s2_addr;
    logic          s2_valid_q;
    lookup_width_t s2_width_q;

    // Bound table written while the symbols stream in
    always_ff @(posedge clk_i)
    begin
        if (bound_wr_i)
        begin
            min_q[table_sel_i][bound_len_i] <= bound_min_i;
            max_q[table_sel_i][bound_len_i] <= bound_max_i;
            ptr_q[table_sel_i][bound_len_i] <= bound_ptr_i;
        end
    end

    //--------------------------------------------------
    // Stage 1: shortest matching length
    //--------------------------------------------------
    always_comb
    begin
        match_len = code_len_t'(`DHT_MAX_CODE_LEN - 1);
        for (int l = `DHT_MAX_CODE_LEN - 2; l >= 0; l--)
        begin
            // Prefix of l+1 bits, MSB first
            if ((lookup_input_i >> (`DHT_MAX_CODE_LEN - 1 - l)) < max_q[lookup_table_i][l])
                match_len = code_len_t'(l);
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            s1_valid_q <= 1'b0;
        else
            s1_valid_q <= lookup_req_i;
    end

    // Window travels with the length so the caller can move on
    always_ff @(posedge clk_i)
    begin
        s1_len_q    <= match_len;
        s1_table_q  <= lookup_table_i;
        s1_window_q <= lookup_input_i;
    end

    //--------------------------------------------------
    // Stage 2: RAM address, aligned with the read
    //--------------------------------------------------
    assign s2_prefix = s1_window_q >> (`DHT_MAX_CODE_LEN - 1 - s1_len_q);
    assign s2_addr   = s2_prefix - min_q[s1_table_q][s1_len_q]
                     + code_t'(ptr_q[s1_table_q][s1_len_q]);
    assign rd_addr_o = s2_addr[`DHT_PTR_W-1:0];

    always_ff @(posedge clk_i)
    begin
        if (rst_i)
            s2_valid_q <= 1'b0;
        else
            s2_valid_q <= s1_valid_q;
    end

    always_ff @(posedge clk_i)
    begin
        s2_width_q <= lookup_width_t'(s1_len_q) + lookup_width_t'(1);
    end

    assign lookup_valid_o = s2_valid_q;
    assign lookup_width_o = s2_width_q;

endmodule

`default_nettype wire

/* rtl/dht_symbol_ram.sv */
//--------------------------------------------------
// DHT symbol RAM
// Decoded symbol bytes with a registered read
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module dht_symbol_ram (
    input  wire                         clk_i,
    input  wire                         wr_en_i,
    input  wire dht_code_pkg::sym_ptr_t wr_addr_i,
    input  wire dht_code_pkg::symbol_t  wr_data_i,
    input  wire dht_code_pkg::sym_ptr_t rd_addr_i,
    output dht_code_pkg::symbol_t       rd_data_o
);
    import dht_code_pkg::*;

    symbol_t mem [`DHT_SYM_RAM_DEPTH];
    symbol_t rd_data_q;

    always_ff @(posedge clk_i)
    begin
        if (wr_en_i)
            mem[wr_addr_i] <= wr_data_i;
    end

    // Read every cycle, lookup valid is tracked in the bounds block
    always_ff @(posedge clk_i)
    begin
        rd_data_q <= mem[rd_addr_i];
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

/* rtl/dht_top.sv */
//--------------------------------------------------
// JPEG Huffman table unit
// Loads DHT segments and decodes the code at the
// top of a 16 bit window
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module dht_top (
    input  wire                            clk_i,
    input  wire                            rst_i,
    input  wire                            cfg_valid_i,
    input  wire dht_load_pkg::cfg_byte_t   cfg_data_i,
    input  wire                            cfg_last_i,
    output logic                           cfg_accept_o,
    input  wire                            lookup_req_i,
    input  wire dht_code_pkg::table_sel_t  lookup_table_i,
    input  wire dht_code_pkg::code_t       lookup_input_i,
    output logic                           lookup_valid_o,
    output dht_code_pkg::symbol_t          lookup_value_o,
    output dht_code_pkg::lookup_width_t    lookup_width_o
);
    import dht_code_pkg::*;

    logic       table_start;
    logic       count_wr;
    logic       sym_step;
    logic       len_skip;
    logic       cur_len_empty;
    logic       bound_wr;
    code_len_t  count_idx;
    code_len_t  bound_len;
    table_sel_t table_sel;
    code_t      bound_min;
    code_t      bound_max;
    sym_ptr_t   next_ptr;
    sym_ptr_t   rd_addr;

    dht_load_fsm u_load_fsm (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .cfg_valid_i     (cfg_valid_i),
        .cfg_data_i      (cfg_data_i),
        .cfg_last_i      (cfg_last_i),
        .cur_len_empty_i (cur_len_empty),
        .cfg_accept_o    (cfg_accept_o),
        .table_start_o   (table_start),
        .count_wr_o      (count_wr),
        .count_idx_o     (count_idx),
        .sym_step_o      (sym_step),
        .len_skip_o      (len_skip),
        .table_sel_o     (table_sel)
    );

    dht_code_gen u_code_gen (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .table_start_i   (table_start),
        .count_wr_i      (count_wr),
        .count_idx_i     (count_idx),
        .count_i         (cfg_data_i),
        .sym_step_i      (sym_step),
        .len_skip_i      (len_skip),
        .cur_len_empty_o (cur_len_empty),
        .bound_wr_o      (bound_wr),
        .bound_len_o     (bound_len),
        .bound_min_o     (bound_min),
        .bound_max_o     (bound_max),
        .next_ptr_o      (next_ptr)
    );

    dht_code_bounds u_code_bounds (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .bound_wr_i     (bound_wr),
        .table_sel_i    (table_sel),
        .bound_len_i    (bound_len),
        .bound_min_i    (bound_min),
        .bound_max_i    (bound_max),
        .bound_ptr_i    (next_ptr),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .rd_addr_o      (rd_addr),
        .lookup_valid_o (lookup_valid_o),
        .lookup_width_o (lookup_width_o)
    );

    // Symbol bytes are written in stream order
    dht_symbol_ram u_symbol_ram (
        .clk_i     (clk_i),
        .wr_en_i   (sym_step),
        .wr_addr_i (next_ptr),
        .wr_data_i (cfg_data_i),
        .rd_addr_i (rd_addr),
        .rd_data_o (lookup_value_o)
    );

endmodule

`default_nettype wire

/* verif/dht_checker.sv */
//--------------------------------------------------
// DHT checker
// Models stream parsing, accept stalls and
// canonical decode, and compares DUT responses
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module dht_checker (
    input  wire                              clk_i,
    input  wire                              rst_i,
    input  wire                              cfg_valid_i,
    input  wire dht_load_pkg::cfg_byte_t     cfg_data_i,
    input  wire                              cfg_last_i,
    input  wire                              cfg_accept_i,
    input  wire                              lookup_req_i,
    input  wire dht_code_pkg::table_sel_t    lookup_table_i,
    input  wire dht_code_pkg::code_t         lookup_input_i,
    input  wire                              lookup_valid_i,
    input  wire dht_code_pkg::symbol_t       lookup_value_i,
    input  wire dht_code_pkg::lookup_width_t lookup_width_i,
    output logic                             busy_o,
    output int                               errors_o,
    output int                               checks_o
);
    import dht_load_pkg::*;
    import dht_code_pkg::*;

    // Table contents as seen on the stream
    int      cnt   [4][`DHT_MAX_CODE_LEN];
    symbol_t sym   [4][256];
    int      n_sym [4];

    load_state_t   st;
    int            tsel;
    int            idx;
    int            remain;
    int            cur_len;
    int            in_len;
    int            cyc;
    int            due_q [$];
    symbol_t       val_q [$];
    lookup_width_t wid_q [$];

    // Walk the canonical codes, shortest length first
    function automatic void decode(input int t, input code_t win, output symbol_t s,
                                   output lookup_width_t w, output bit ok);
        int code;
        int k;
        code = 0;
        k    = 0;
        ok   = 1'b0;
        s    = '0;
        w    = '0;
        for (int l = 1; l <= `DHT_MAX_CODE_LEN; l++)
        begin
            for (int i = 0; i < cnt[t][l - 1]; i++)
            begin
                if (!ok && (int'(win >> (`DHT_MAX_CODE_LEN - l)) == code))
                begin
                    s  = sym[t][k];
                    w  = lookup_width_t'(l);
                    ok = 1'b1;
                end
                code = code + 1;
                k    = k + 1;
            end
            code = code << 1;
        end
    endfunction

    task automatic take_byte(input cfg_byte_t b, input logic last);
        case (st)
            LOAD_TABLE_ID:
            begin
                case (b)
                    `DHT_ID_Y_DC:  tsel = 0;
                    `DHT_ID_Y_AC:  tsel = 1;
                    `DHT_ID_CX_DC: tsel = 2;
                    default:       tsel = 3;
                endcase
                for (int l = 0; l < `DHT_MAX_CODE_LEN; l++)
                    cnt[tsel][l] = 0;
                n_sym[tsel] = 0;
                idx         = 0;
                remain      = 0;
                cur_len     = 0;
                in_len      = 0;
                if (!last)
                    st = LOAD_COUNTS;
            end
            LOAD_COUNTS:
            begin
                cnt[tsel][idx] = int'(b);
                remain         = remain + int'(b);
                idx            = idx + 1;
                if (last)
                    st = LOAD_TABLE_ID;
                else if (idx == `DHT_MAX_CODE_LEN)
                    st = (remain == 0) ? LOAD_TABLE_ID : LOAD_SYMBOLS;
            end
            default:
            begin
                if (n_sym[tsel] < 256)
                    sym[tsel][n_sym[tsel]] = b;
                n_sym[tsel] = n_sym[tsel] + 1;
                in_len      = in_len + 1;
                if (in_len == cnt[tsel][cur_len])
                begin
                    cur_len = cur_len + 1;
                    in_len  = 0;
                end
                remain = remain - 1;
                if (last || (remain == 0))
                    st = LOAD_TABLE_ID;
            end
        endcase
    endtask

    //--------------------------------------------------
    // Compare at the falling edge, all values settled
    //--------------------------------------------------
    always @(negedge clk_i)
    begin : watch
        logic          exp_acc;
        symbol_t       s;
        lookup_width_t w;
        bit            ok;
        if (rst_i)
        begin
            st       = LOAD_TABLE_ID;
            cyc      = 0;
            busy_o   = 1'b0;
            errors_o = 0;
            checks_o = 0;
            due_q.delete();
            val_q.delete();
            wid_q.delete();
        end
        else
        begin
            cyc = cyc + 1;
            // One stall per empty length in the symbol phase
            exp_acc = !((st == LOAD_SYMBOLS) && (cnt[tsel][cur_len] == 0));
            if (cfg_accept_i !== exp_acc)
            begin
                errors_o = errors_o + 1;
                $display("Fail cfg_accept_o got %h expected %h", cfg_accept_i, exp_acc);
            end
            if (cfg_valid_i && exp_acc)
                take_byte(cfg_data_i, cfg_last_i);
            else if (cfg_valid_i)
                cur_len = cur_len + 1;

            if ((due_q.size() != 0) && (due_q[0] == cyc))
            begin
                if (lookup_valid_i !== 1'b1)
                begin
                    errors_o = errors_o + 1;
                    $display("Lookup result missing two cycles after its request");
                end
                else
                begin
                    checks_o = checks_o + 1;
                    if (lookup_value_i !== val_q[0])
                    begin
                        errors_o = errors_o + 1;
                        $display("Fail lookup_value_o got %h expected %h",
                                 lookup_value_i, val_q[0]);
                    end
                    if (lookup_width_i !== wid_q[0])
                    begin
                        errors_o = errors_o + 1;
                        $display("Fail lookup_width_o got %h expected %h",
                                 lookup_width_i, wid_q[0]);
                    end
                end
                void'(due_q.pop_front());
                void'(val_q.pop_front());
                void'(wid_q.pop_front());
            end
            else if (lookup_valid_i !== 1'b0)
            begin
                errors_o = errors_o + 1;
                $display("Lookup valid pulse without a matching request");
            end

            // Request is sampled at the next rising edge
            if (lookup_req_i)
            begin
                decode(int'(lookup_table_i), lookup_input_i, s, w, ok);
                if (!ok)
                begin
                    errors_o = errors_o + 1;
                    $display("Lookup window does not hold a valid code of its table");
                end
                due_q.push_back(cyc + 2);
                val_q.push_back(s);
                wid_q.push_back(w);
            end
            busy_o = (due_q.size() != 0);
        end
    end

endmodule

`default_nettype wire

/* verif/tb_dht_top.sv */
//--------------------------------------------------
// DHT table unit testbench
// Random tables, stream loading with idle gaps,
// single and back to back lookups, table reload
//--------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

`include "dht_consts.svh"

module tb_dht_top;
    import dht_code_pkg::*;

    // 4 single lookups, 40 back to back, 8 after the reload
    localparam int LOOKUPS = 52;

    logic          clk_i;
    logic          rst_i;
    logic          cfg_valid_i;
    logic [7:0]    cfg_data_i;
    logic          cfg_last_i;
    logic          cfg_accept_o;
    logic          lookup_req_i;
    table_sel_t    lookup_table_i;
    code_t         lookup_input_i;
    logic          lookup_valid_o;
    symbol_t       lookup_value_o;
    lookup_width_t lookup_width_o;
    logic          busy;
    int            errors;
    int            checks;

    // Generated tables, slot 4 holds the reload contents
    int         cnt_g  [5][16];
    symbol_t    sym_g  [5][40];
    int         code_g [5][40];
    int         len_g  [5][40];
    int         n_g    [5];
    logic [8:0] stream_q [$];
    int         idle_q   [$];
    int         cycles;
    int         limit;
    int         reload_t;
    int         first_len;
    int         fails;

    dht_top u_dht_top (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_last_i     (cfg_last_i),
        .cfg_accept_o   (cfg_accept_o),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lookup_valid_o (lookup_valid_o),
        .lookup_value_o (lookup_value_o),
        .lookup_width_o (lookup_width_o)
    );

    dht_checker u_checker (
        .clk_i          (clk_i),
        .rst_i          (rst_i),
        .cfg_valid_i    (cfg_valid_i),
        .cfg_data_i     (cfg_data_i),
        .cfg_last_i     (cfg_last_i),
        .cfg_accept_i   (cfg_accept_o),
        .lookup_req_i   (lookup_req_i),
        .lookup_table_i (lookup_table_i),
        .lookup_input_i (lookup_input_i),
        .lookup_valid_i (lookup_valid_o),
        .lookup_value_i (lookup_value_o),
        .lookup_width_i (lookup_width_o),
        .busy_o         (busy),
        .errors_o       (errors),
        .checks_o       (checks)
    );

    always #5 clk_i = ~clk_i;

    // Run limit from the stream and lookup length
    always @(posedge clk_i)
    begin
        cycles = cycles + 1;
        if (cycles > limit)
        begin
            $display("Timeout after %0d cycles, the run did not finish", cycles);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    function automatic logic [7:0] id_of(input int t);
        case (t)
            0:       return `DHT_ID_Y_DC;
            1:       return `DHT_ID_Y_AC;
            2:       return `DHT_ID_CX_DC;
            default: return `DHT_ID_CX_AC;
        endcase
    endfunction

    // Counts leave one code free at every length, so no all ones code
    task automatic make_table(input int s);
        int avail;
        int code;
        int n;
        avail = 1;
        code  = 0;
        n     = 0;
        for (int l = 0; l < 16; l++)
        begin
            avail       = (avail > 127) ? 255 : avail * 2;
            cnt_g[s][l] = 0;
            if (($urandom % 3 == 0) && (avail > 1) && (n < 40))
                cnt_g[s][l] = 1 + $urandom % ((avail - 1 < 40 - n) ? avail - 1 : 40 - n);
            avail = avail - cnt_g[s][l];
            n     = n + cnt_g[s][l];
        end
        if (n == 0)
            cnt_g[s][15] = 1;
        n = 0;
        for (int l = 0; l < 16; l++)
        begin
            for (int i = 0; i < cnt_g[s][l]; i++)
            begin
                sym_g[s][n]  = symbol_t'($urandom);
                code_g[s][n] = code;
                len_g[s][n]  = l + 1;
                code         = code + 1;
                n            = n + 1;
            end
            code = code << 1;
        end
        n_g[s] = n;
    endtask

    // Symbol bytes get no idle gap, valid stays high in that phase
    task automatic queue_table(input int s, input int t, input bit last_end);
        stream_q.push_back({1'b0, id_of(t)});
        idle_q.push_back($urandom % 4);
        for (int l = 0; l < 16; l++)
        begin
            stream_q.push_back({1'b0, 8'(cnt_g[s][l])});
            idle_q.push_back($urandom % 3);
        end
        for (int i = 0; i < n_g[s]; i++)
        begin
            stream_q.push_back({last_end && (i == n_g[s] - 1), sym_g[s][i]});
            idle_q.push_back(0);
        end
    endtask

    task automatic send_bytes(input int first, input int stop);
        for (int i = first; i < stop; i++)
        begin
            if (idle_q[i] != 0)
            begin
                cfg_valid_i = 1'b0;
                repeat (idle_q[i]) @(posedge clk_i);
                #1;
            end
            cfg_valid_i = 1'b1;
            cfg_data_i  = stream_q[i][7:0];
            cfg_last_i  = stream_q[i][8];
            @(negedge clk_i);
            while (!cfg_accept_o)
                @(negedge clk_i);
            @(posedge clk_i);
            #1;
        end
        cfg_valid_i = 1'b0;
        cfg_last_i  = 1'b0;
    endtask

    // Valid code padded with random low bits
    task automatic issue_lookup(input int t);
        int k;
        int len;
        k              = $urandom % n_g[t];
        len            = len_g[t][k];
        lookup_req_i   = 1'b1;
        lookup_table_i = table_sel_t'(t);
        lookup_input_i = code_t'((code_g[t][k] << (16 - len))
                       | ($urandom & ((1 << (16 - len)) - 1)));
        @(posedge clk_i);
        #1;
        lookup_req_i   = 1'b0;
        lookup_input_i = code_t'($urandom);
    endtask

    task automatic wait_results();
        while (busy)
            @(posedge clk_i);
        #1;
    endtask

    initial
    begin
        void'($urandom(32'h415f_f0df));
        clk_i          = 1'b0;
        rst_i          = 1'b1;
        cfg_valid_i    = 1'b0;
        cfg_data_i     = '0;
        cfg_last_i     = 1'b0;
        lookup_req_i   = 1'b0;
        lookup_table_i = '0;
        lookup_input_i = '0;
        cycles         = 0;
        for (int s = 0; s < 5; s++)
            make_table(s);
        reload_t = $urandom % 4;
        for (int t = 0; t < 4; t++)
            queue_table(t, t, 1'b0);
        first_len = stream_q.size();
        queue_table(4, reload_t, 1'b1);
        limit = stream_q.size() + LOOKUPS;
        foreach (idle_q[i])
            limit = limit + idle_q[i];
        limit = 2 * limit + 200;

        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        // Quiet outputs are watched before any stimulus
        repeat (2) @(posedge clk_i);
        #1;

        // All four tables in one stream, each ends on its own
        send_bytes(0, first_len);
        for (int t = 0; t < 4; t++)
        begin
            issue_lookup(t);
            wait_results();
        end

        // One request per cycle over random tables
        for (int i = 0; i < 40; i++)
            issue_lookup($urandom % 4);
        wait_results();

        // Reload one table, stream closed with the last flag
        send_bytes(first_len, stream_q.size());
        for (int i = 0; i < 40; i++)
        begin
            code_g[reload_t][i] = code_g[4][i];
            len_g[reload_t][i]  = len_g[4][i];
        end
        n_g[reload_t] = n_g[4];
        // Reloaded table first, then each of the other three
        for (int i = 0; i < 8; i++)
            issue_lookup((i < 4) ? reload_t : (reload_t + 1 + i % 3) % 4);
        wait_results();
        repeat (2) @(posedge clk_i);

        fails = errors;
        if (checks != LOOKUPS)
        begin
            $display("Only %0d of %0d lookup results were checked", checks, LOOKUPS);
            fails = fails + 1;
        end
        $display("Run done: %0d errors, %0d lookups checked", fails, checks);
        if (fails == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+rtl
rtl/dht_load_pkg.sv
rtl/dht_code_pkg.sv
rtl/dht_load_fsm.sv
rtl/dht_code_gen.sv
rtl/dht_code_bounds.sv
rtl/dht_symbol_ram.sv
rtl/dht_top.sv
verif/dht_checker.sv
verif/tb_dht_top.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the DHT table unit testbench with Verilator
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
OBJ=obj_dir

verilator --binary -Wno-fatal -f verilog.f --top-module tb_dht_top \
    -Mdir "$OBJ" -o sim_tb_dht_top
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit 1
fi

"./$OBJ/sim_tb_dht_top" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "Simulation reported failures, see $LOG"
    exit 1
fi

echo "Simulation finished without failures"
exit 0
